/* include/cmac_settings.svh */
`ifndef CMAC_SETTINGS_SVH
`define CMAC_SETTINGS_SVH

// Width of the wrapping statistics counters
`define STAT_CNT_W 32

// Bad-FCS increment the MAC reports per cycle
`define FCS_CNT_W 3

// AXI4-Lite register port
`define CSR_ADDR_W 6
`define CSR_DATA_W 32

// Depth of the status synchronizers
`define SYNC_STAGES 3

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CMAC statistics testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f sources.f \
    --top-module cmac_stats_tb \
    -Mdir "$BUILD_DIR" \
    -o cmac_stats_sim

"./$BUILD_DIR/cmac_stats_sim" | tee "$LOG_FILE"

if grep -qx "Finished with no errors" "$LOG_FILE"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

/* sources.f */
+incdir+include
verilog/stream_stats_pkg.sv
verilog/csr_map_pkg.sv
verilog/rx_stream_monitor.sv
verilog/tx_stream_monitor.sv
verilog/link_status_sync.sv
verilog/stats_csr_ctrl.sv
verilog/cmac_stats_top.sv
testbench/cmac_stats_asserts.sv
testbench/cmac_stats_tb.sv

/* testbench/cmac_stats_asserts.sv */
module cmac_stats_asserts
    import csr_map_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      b_valid,
    input logic      b_ready,
    input logic      ar_ready,
    input logic      r_valid,
    input logic      r_ready,
    input csr_data_t r_data,
    input logic      clear_stats
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write response waits for the master
    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before b_ready");

    // Read data stays put until taken
    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r_data))
        else $error("r_valid or r_data changed before r_ready");

    clear_pulse: assert property (@(posedge clk) disable iff (rst)
        clear_stats |=> !clear_stats)
        else $error("clear_stats held longer than one cycle");

    // No new read while one is pending
    ar_blocked: assert property (@(posedge clk) disable iff (rst)
        r_valid |-> !ar_ready)
        else $error("ar_ready pulsed with read data pending");

endmodule

bind stats_csr_ctrl cmac_stats_asserts cmac_stats_asserts_inst (
    .clk,
    .rst,
    .b_valid,
    .b_ready,
    .ar_ready,
    .r_valid,
    .r_ready,
    .r_data,
    .clear_stats
);

/* testbench/cmac_stats_tb.sv */
module cmac_stats_tb
    import stream_stats_pkg::*;
    import csr_map_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD         = 40;
    localparam int RESET_CYCLES   = 3;
    localparam int SEED           = 28675;
    localparam int CYCLES_PER_VEC = 20;
    localparam int MARGIN_CYCLES  = 100;

    logic      gt_init_clk;
    logic      rst;
    logic      rx_valid;
    logic      rx_ready;
    logic      rx_last;
    fcs_inc_t  rx_bad_fcs;
    fcs_inc_t  rx_stomped_fcs;
    logic      tx_valid;
    logic      tx_ready;
    logic      tx_last;
    logic      tx_ovf;
    logic      tx_unf;
    logic      qsfp_fault_in;
    logic      rx_aligned_in;
    logic      aw_valid;
    logic      aw_ready;
    csr_addr_t aw_addr;
    logic      w_valid;
    logic      w_ready;
    csr_data_t w_data;
    csr_strb_t w_strb;
    logic      b_valid;
    logic      b_ready;
    axi_resp_e b_resp;
    logic      ar_valid;
    logic      ar_ready;
    csr_addr_t ar_addr;
    logic      r_valid;
    logic      r_ready;
    csr_data_t r_data;
    axi_resp_e r_resp;
    logic      qsfp_lpmode_out;
    logic      qsfp_resetl_out;
    logic      qsfp_fault_indication;
    logic      rx_aligned_indication;

    // Vector table with one entry per command line
    string       cmd_q[$];
    string       name_q[$];
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];
    logic [31:0] c_q[$];
    logic [31:0] d_q[$];
    logic [31:0] e_q[$];
    int          vec_count;
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_errors;
    int          test_checks;

    cmac_stats_top cmac_stats_top_inst (.*);

    initial begin
        gt_init_clk = 1'b0;
        forever #(PERIOD / 2) gt_init_clk = ~gt_init_clk;
    end

    task automatic load_vectors();
        int          vfile;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] fa;
        logic [31:0] fb;
        logic [31:0] fc;
        logic [31:0] fd;
        logic [31:0] fe;
        vfile = $fopen("testbench/cmac_stats_vectors.txt", "r");
        if (vfile == 0) begin
            return;
        end
        while ($fgets(line, vfile) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            name = "";
            fa   = '0;
            fb   = '0;
            fc   = '0;
            fd   = '0;
            fe   = '0;
            void'($sscanf(line, "%s", cmd));
            if (cmd == "E") begin
                void'($sscanf(line, "%s %s", cmd, name));
            end else begin
                void'($sscanf(line, "%s %h %h %h %h %h", cmd, fa, fb, fc, fd, fe));
            end
            cmd_q.push_back(cmd);
            name_q.push_back(name);
            a_q.push_back(fa);
            b_q.push_back(fb);
            c_q.push_back(fc);
            d_q.push_back(fd);
            e_q.push_back(fe);
        end
        $fclose(vfile);
        vec_count = cmd_q.size();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        test_checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    // Stream inputs back to an idle bus from the current edge
    task automatic set_streams_idle();
        rx_valid   <= 1'b0;
        rx_ready   <= 1'b0;
        rx_last    <= 1'b0;
        rx_bad_fcs <= '0;
        tx_valid   <= 1'b0;
        tx_ready   <= 1'b0;
        tx_last    <= 1'b0;
        tx_ovf     <= 1'b0;
        tx_unf     <= 1'b0;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 3;
        if (gap != 0) begin
            @(posedge gt_init_clk);
            set_streams_idle();
            repeat (gap - 1) @(posedge gt_init_clk);
        end
    endtask

    task automatic rx_beat(input logic valid, input logic ready, input logic last,
                           input fcs_inc_t fcs);
        @(posedge gt_init_clk);
        set_streams_idle();
        rx_valid   <= valid;
        rx_ready   <= ready;
        rx_last    <= last;
        rx_bad_fcs <= fcs;
        idle_gap();
    endtask

    task automatic tx_beat(input logic valid, input logic ready, input logic last,
                           input logic ovf, input logic unf);
        @(posedge gt_init_clk);
        set_streams_idle();
        tx_valid <= valid;
        tx_ready <= ready;
        tx_last  <= last;
        tx_ovf   <= ovf;
        tx_unf   <= unf;
        idle_gap();
    endtask

    task automatic axi_write(input csr_addr_t addr, input csr_data_t data,
                             output logic [1:0] resp);
        int delay;
        delay = $urandom % 4;
        @(posedge gt_init_clk);
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
        aw_addr  <= addr;
        w_data   <= data;
        w_strb   <= '1;
        @(negedge gt_init_clk);
        while (!(aw_ready && w_ready)) @(negedge gt_init_clk);
        @(posedge gt_init_clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        // Master stalls the response for a few cycles
        repeat (delay) @(posedge gt_init_clk);
        b_ready <= 1'b1;
        @(negedge gt_init_clk);
        while (!b_valid) @(negedge gt_init_clk);
        resp = b_resp;
        @(posedge gt_init_clk);
        b_ready <= 1'b0;
    endtask

    task automatic axi_read(input csr_addr_t addr, output csr_data_t data,
                            output logic [1:0] resp);
        int delay;
        delay = $urandom % 4;
        @(posedge gt_init_clk);
        ar_valid <= 1'b1;
        ar_addr  <= addr;
        @(negedge gt_init_clk);
        while (!ar_ready) @(negedge gt_init_clk);
        @(posedge gt_init_clk);
        ar_valid <= 1'b0;
        repeat (delay) @(posedge gt_init_clk);
        r_ready <= 1'b1;
        @(negedge gt_init_clk);
        while (!r_valid) @(negedge gt_init_clk);
        data = r_data;
        resp = r_resp;
        @(posedge gt_init_clk);
        r_ready <= 1'b0;
    endtask

    // Indications keep the old value for two edges and change after the third
    task automatic status_step(input logic fault, input logic aligned);
        logic old_fault;
        logic old_aligned;
        old_fault   = qsfp_fault_in;
        old_aligned = rx_aligned_in;
        @(posedge gt_init_clk);
        qsfp_fault_in <= fault;
        rx_aligned_in <= aligned;
        repeat (3) @(negedge gt_init_clk);
        check_value("fault indication before delay", {31'b0, qsfp_fault_indication},
                    {31'b0, old_fault});
        check_value("aligned indication before delay", {31'b0, rx_aligned_indication},
                    {31'b0, old_aligned});
        @(negedge gt_init_clk);
        check_value("fault indication after delay", {31'b0, qsfp_fault_indication},
                    {31'b0, fault});
        check_value("aligned indication after delay", {31'b0, rx_aligned_indication},
                    {31'b0, aligned});
    endtask

    task automatic run_vector(input int idx);
        csr_data_t   data;
        logic [1:0]  resp;
        string       what;
        if (cmd_q[idx] != "R" && cmd_q[idx] != "T") begin
            @(posedge gt_init_clk);
            set_streams_idle();
        end
        case (cmd_q[idx])
            "R": rx_beat(a_q[idx][0], b_q[idx][0], c_q[idx][0], d_q[idx][2:0]);
            "T": tx_beat(a_q[idx][0], b_q[idx][0], c_q[idx][0], d_q[idx][0], e_q[idx][0]);
            "W": begin
                axi_write(a_q[idx][5:0], b_q[idx], resp);
                what = $sformatf("write response at 0x%02h", a_q[idx][5:0]);
                check_value(what, {30'b0, resp}, {30'b0, c_q[idx][1:0]});
            end
            "C": begin
                axi_read(a_q[idx][5:0], data, resp);
                what = $sformatf("read data at 0x%02h", a_q[idx][5:0]);
                check_value(what, data, b_q[idx]);
                what = $sformatf("read response at 0x%02h", a_q[idx][5:0]);
                check_value(what, {30'b0, resp}, {30'b0, c_q[idx][1:0]});
            end
            "F": status_step(a_q[idx][0], b_q[idx][0]);
            "Q": begin
                @(negedge gt_init_clk);
                check_value("qsfp_lpmode_out", {31'b0, qsfp_lpmode_out}, {31'b0, a_q[idx][0]});
                check_value("qsfp_resetl_out", {31'b0, qsfp_resetl_out}, {31'b0, b_q[idx][0]});
            end
            "E": begin
                test_count++;
                $display("Test %-16s %s  (%0d checks, %0d errors)", name_q[idx],
                         (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
                test_errors = 0;
                test_checks = 0;
            end
            default: begin
                $display("Vector %0d has an unknown command '%s' and was not run",
                         idx, cmd_q[idx]);
                error_count++;
            end
        endcase
    endtask

    initial begin
        rst            <= 1'b1;
        rx_stomped_fcs <= '0;
        qsfp_fault_in  <= 1'b0;
        rx_aligned_in  <= 1'b0;
        aw_valid       <= 1'b0;
        aw_addr        <= '0;
        w_valid        <= 1'b0;
        w_data         <= '0;
        w_strb         <= '0;
        b_ready        <= 1'b0;
        ar_valid       <= 1'b0;
        ar_addr        <= '0;
        r_ready        <= 1'b0;
        set_streams_idle();
        void'($urandom(SEED));
        load_vectors();
        if (vec_count == 0) begin
            $display("Vector file testbench/cmac_stats_vectors.txt is missing or empty");
            $display("Finished with errors");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge gt_init_clk);
            rst <= 1'b0;
            for (int i = 0; i < vec_count; i++) begin
                run_vector(i);
            end
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of vectors
    initial begin
        wait (vec_count > 0);
        #((vec_count * CYCLES_PER_VEC + MARGIN_CYCLES) * PERIOD);
        $display("Watchdog: the run timed out before all vectors were played");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* testbench/cmac_stats_vectors.txt */
# R valid ready last bad_fcs | T valid ready last ovf unf | F fault aligned | Q lpmode resetl
# W addr data exp_resp | C addr exp_data exp_resp | E test_name   (hex, resp 0 OKAY 2 SLVERR)
Q 0 1
C 00 00000002 0
C 04 00000018 0
C 08 00000000 0
C 0C 00000000 0
C 10 00000000 0
C 14 00000000 0
C 18 00000000 0
C 1C 00000000 0
C 20 00000000 0
C 24 00000000 0
C 28 00000000 0
C 2C 00000000 0
E reset_values
R 1 1 0 0
R 1 0 0 0
R 1 1 0 0
R 1 1 1 2
R 1 1 1 1
R 0 1 0 3
C 08 00000002 0
C 0C 00000004 0
C 10 00000001 0
C 14 00000006 0
C 18 00000003 0
C 04 00000018 0
E rx_counts
T 1 1 0 1 0
T 1 1 0 0 0
T 1 0 0 0 1
T 1 1 0 0 0
T 1 1 1 0 0
T 1 1 1 0 0
T 0 0 0 1 1
C 1C 00000002 0
C 20 00000005 0
C 24 00000004 0
C 28 00000002 0
C 2C 00000002 0
C 04 00000018 0
E tx_counts
W 00 00000006 0
C 08 00000000 0
C 10 00000000 0
C 14 00000000 0
C 1C 00000000 0
C 24 00000000 0
C 2C 00000000 0
C 00 00000002 0
W 00 00000003 0
Q 1 1
C 00 00000003 0
W 00 00000002 0
Q 0 1
E counter_clear
F 0 1
F 1 1
F 0 1
C 04 0000001E 0
W 04 00000004 0
C 04 0000001A 0
E link_status
R 1 1 1 0
C 08 00000001 0
C 30 00000000 2
C 3C 00000000 2
W 08 FFFFFFFF 2
C 08 00000001 0
W 2C 00000005 2
C 2C 00000000 0
W 30 00000001 2
E error_responses

/* verilog/cmac_stats_top.sv */
`include "cmac_settings.svh"

module cmac_stats_top
    import stream_stats_pkg::*;
    import csr_map_pkg::*;
(
    input  logic      gt_init_clk,
    input  logic      rst,

    input  logic      rx_valid,
    input  logic      rx_ready,
    input  logic      rx_last,
    input  fcs_inc_t  rx_bad_fcs,
    // No statistic uses it
    input  fcs_inc_t  rx_stomped_fcs,

    input  logic      tx_valid,
    input  logic      tx_ready,
    input  logic      tx_last,
    input  logic      tx_ovf,
    input  logic      tx_unf,

    input  logic      qsfp_fault_in,
    input  logic      rx_aligned_in,

    input  logic      aw_valid,
    output logic      aw_ready,
    input  csr_addr_t aw_addr,
    input  logic      w_valid,
    output logic      w_ready,
    input  csr_data_t w_data,
    input  csr_strb_t w_strb,
    output logic      b_valid,
    input  logic      b_ready,
    output axi_resp_e b_resp,
    input  logic      ar_valid,
    output logic      ar_ready,
    input  csr_addr_t ar_addr,
    output logic      r_valid,
    input  logic      r_ready,
    output csr_data_t r_data,
    output axi_resp_e r_resp,

    output logic      qsfp_lpmode_out,
    output logic      qsfp_resetl_out,
    output logic      qsfp_fault_indication,
    output logic      rx_aligned_indication
);

    stat_cnt_t rx_pkt_cnt;
    stat_cnt_t rx_beat_cnt;
    stat_cnt_t rx_lost_cnt;
    stat_cnt_t rx_bad_fcs_cnt;
    stat_cnt_t rx_max_pkt;
    stat_cnt_t tx_pkt_cnt;
    stat_cnt_t tx_beat_cnt;
    stat_cnt_t tx_max_pkt;
    stat_cnt_t tx_ovf_cnt;
    stat_cnt_t tx_unf_cnt;
    logic      rx_idle;
    logic      tx_idle;
    logic      fault_sticky;
    logic      clear_stats;
    logic      clear_fault_sticky;

    rx_stream_monitor rx_stream_monitor_inst (
        .clk         (gt_init_clk),
        .rst,
        .clear_stats,
        .rx_valid,
        .rx_ready,
        .rx_last,
        .rx_bad_fcs,
        .pkt_cnt     (rx_pkt_cnt),
        .beat_cnt    (rx_beat_cnt),
        .lost_cnt    (rx_lost_cnt),
        .bad_fcs_cnt (rx_bad_fcs_cnt),
        .max_pkt     (rx_max_pkt),
        .idle        (rx_idle)
    );

    tx_stream_monitor tx_stream_monitor_inst (
        .clk         (gt_init_clk),
        .rst,
        .clear_stats,
        .tx_valid,
        .tx_ready,
        .tx_last,
        .tx_ovf,
        .tx_unf,
        .pkt_cnt     (tx_pkt_cnt),
        .beat_cnt    (tx_beat_cnt),
        .max_pkt     (tx_max_pkt),
        .ovf_cnt     (tx_ovf_cnt),
        .unf_cnt     (tx_unf_cnt),
        .idle        (tx_idle)
    );

    link_status_sync #(
        .STAGES (`SYNC_STAGES)
    ) link_status_sync_inst (
        .clk          (gt_init_clk),
        .rst,
        .qsfp_fault_in,
        .rx_aligned_in,
        .clear_fault_sticky,
        .fault        (qsfp_fault_indication),
        .aligned      (rx_aligned_indication),
        .fault_sticky
    );

    stats_csr_ctrl stats_csr_ctrl_inst (
        .clk     (gt_init_clk),
        .rst,
        .aw_valid,
        .aw_ready,
        .aw_addr,
        .w_valid,
        .w_ready,
        .w_data,
        .w_strb,
        .b_valid,
        .b_ready,
        .b_resp,
        .ar_valid,
        .ar_ready,
        .ar_addr,
        .r_valid,
        .r_ready,
        .r_data,
        .r_resp,
        .rx_pkt_cnt,
        .rx_beat_cnt,
        .rx_lost_cnt,
        .rx_bad_fcs_cnt,
        .rx_max_pkt,
        .tx_pkt_cnt,
        .tx_beat_cnt,
        .tx_max_pkt,
        .tx_ovf_cnt,
        .tx_unf_cnt,
        .rx_idle,
        .tx_idle,
        .fault   (qsfp_fault_indication),
        .aligned (rx_aligned_indication),
        .fault_sticky,
        .qsfp_lpmode_out,
        .qsfp_resetl_out,
        .clear_stats,
        .clear_fault_sticky
    );

endmodule

/* verilog/csr_map_pkg.sv */
`include "cmac_settings.svh"

package csr_map_pkg;

    typedef logic [`CSR_ADDR_W-1:0]   csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0]   csr_data_t;
    typedef logic [`CSR_DATA_W/8-1:0] csr_strb_t;

    // Byte address of each word register
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CTRL       = 6'h00,
        CSR_STATUS     = 6'h04,
        CSR_RX_PKT     = 6'h08,
        CSR_RX_BEAT    = 6'h0C,
        CSR_RX_LOST    = 6'h10,
        CSR_RX_BAD_FCS = 6'h14,
        CSR_RX_MAX     = 6'h18,
        CSR_TX_PKT     = 6'h1C,
        CSR_TX_BEAT    = 6'h20,
        CSR_TX_MAX     = 6'h24,
        CSR_TX_OVF     = 6'h28,
        CSR_TX_UNF     = 6'h2C
    } csr_addr_e;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_SLVERR = 2'b10
    } axi_resp_e;

    // CTRL bits
    localparam int CTRL_LPMODE_BIT = 0;
    localparam int CTRL_RESETL_BIT = 1;
    localparam int CTRL_CLEAR_BIT  = 2;

    // STATUS bits
    localparam int STAT_FAULT_BIT   = 0;
    localparam int STAT_ALIGNED_BIT = 1;
    localparam int STAT_STICKY_BIT  = 2;
    localparam int STAT_RX_IDLE_BIT = 3;
    localparam int STAT_TX_IDLE_BIT = 4;

endpackage

/* verilog/link_status_sync.sv */
`include "cmac_settings.svh"

module link_status_sync #(
    parameter int STAGES = `SYNC_STAGES
) (
    input  logic clk,
    input  logic rst,
    input  logic qsfp_fault_in,
    input  logic rx_aligned_in,
    input  logic clear_fault_sticky,
    output logic fault,
    output logic aligned,
    output logic fault_sticky
);

    logic [STAGES-1:0] fault_sync;
    logic [STAGES-1:0] aligned_sync;

    // Both inputs are asynchronous to gt_init_clk
    always_ff @(posedge clk) begin
        if (rst) begin
            fault_sync   <= '0;
            aligned_sync <= '0;
        end else begin
            fault_sync   <= {fault_sync[STAGES-2:0], qsfp_fault_in};
            aligned_sync <= {aligned_sync[STAGES-2:0], rx_aligned_in};
        end
    end

    assign fault   = fault_sync[STAGES-1];
    assign aligned = aligned_sync[STAGES-1];

    // A fault in the clear cycle keeps the flag set
    always_ff @(posedge clk) begin
        if (rst) begin
            fault_sticky <= 1'b0;
        end else if (fault) begin
            fault_sticky <= 1'b1;
        end else if (clear_fault_sticky) begin
            fault_sticky <= 1'b0;
        end
    end

endmodule

/* verilog/rx_stream_monitor.sv */
module rx_stream_monitor
    import stream_stats_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear_stats,

    input  logic      rx_valid,
    input  logic      rx_ready,
    input  logic      rx_last,
    input  fcs_inc_t  rx_bad_fcs,

    output stat_cnt_t pkt_cnt,
    output stat_cnt_t beat_cnt,
    output stat_cnt_t lost_cnt,
    output stat_cnt_t bad_fcs_cnt,
    output stat_cnt_t max_pkt,
    output logic      idle
);

    logic      beat_acc;
    logic      beat_lost;
    logic      pkt_open;
    stat_cnt_t cur_beats;
    stat_cnt_t pkt_len;

    assign beat_acc  = rx_valid && rx_ready;
    assign beat_lost = rx_valid && !rx_ready;

    // Packet length counting the beat on the bus now
    assign pkt_len = cur_beats + STAT_ONE;
    assign idle    = !pkt_open;

    always_ff @(posedge clk) begin
        if (rst || clear_stats) begin
            beat_cnt    <= '0;
            lost_cnt    <= '0;
            bad_fcs_cnt <= '0;
        end else begin
            if (beat_acc) begin
                beat_cnt <= beat_cnt + STAT_ONE;
            end
            if (beat_lost) begin
                lost_cnt <= lost_cnt + STAT_ONE;
            end
            // MAC may flag several bad frames in one cycle
            bad_fcs_cnt <= bad_fcs_cnt + stat_cnt_t'(rx_bad_fcs);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_stats) begin
            pkt_cnt   <= '0;
            max_pkt   <= '0;
            cur_beats <= '0;
            pkt_open  <= 1'b0;
        end else if (beat_acc) begin
            if (rx_last) begin
                pkt_cnt   <= pkt_cnt + STAT_ONE;
                cur_beats <= '0;
                pkt_open  <= 1'b0;
                if (pkt_len > max_pkt) begin
                    max_pkt <= pkt_len;
                end
            end else begin
                cur_beats <= pkt_len;
                pkt_open  <= 1'b1;
            end
        end
    end

endmodule

/* verilog/stats_csr_ctrl.sv */
module stats_csr_ctrl
    import stream_stats_pkg::*;
    import csr_map_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      aw_valid,
    output logic      aw_ready,
    input  csr_addr_t aw_addr,
    input  logic      w_valid,
    output logic      w_ready,
    input  csr_data_t w_data,
    input  csr_strb_t w_strb,
    output logic      b_valid,
    input  logic      b_ready,
    output axi_resp_e b_resp,
    input  logic      ar_valid,
    output logic      ar_ready,
    input  csr_addr_t ar_addr,
    output logic      r_valid,
    input  logic      r_ready,
    output csr_data_t r_data,
    output axi_resp_e r_resp,

    input  stat_cnt_t rx_pkt_cnt,
    input  stat_cnt_t rx_beat_cnt,
    input  stat_cnt_t rx_lost_cnt,
    input  stat_cnt_t rx_bad_fcs_cnt,
    input  stat_cnt_t rx_max_pkt,
    input  stat_cnt_t tx_pkt_cnt,
    input  stat_cnt_t tx_beat_cnt,
    input  stat_cnt_t tx_max_pkt,
    input  stat_cnt_t tx_ovf_cnt,
    input  stat_cnt_t tx_unf_cnt,
    input  logic      rx_idle,
    input  logic      tx_idle,
    input  logic      fault,
    input  logic      aligned,
    input  logic      fault_sticky,

    output logic      qsfp_lpmode_out,
    output logic      qsfp_resetl_out,
    output logic      clear_stats,
    output logic      clear_fault_sticky
);

    logic      wr_accept;
    logic      wr_ok;
    logic      wr_ctrl;
    logic      wr_status;
    logic      rd_accept;
    csr_data_t rd_word;
    axi_resp_e rd_resp;
    csr_data_t ctrl_word;
    csr_data_t status_word;
    logic      lpmode_q;
    logic      resetl_q;

    // Address and data accepted together with one write in flight
    assign wr_accept = aw_valid && w_valid && !b_valid;
    assign aw_ready  = wr_accept;
    assign w_ready   = wr_accept;

    // Only CTRL and STATUS take writes
    assign wr_ok     = (csr_addr_e'(aw_addr) == CSR_CTRL) || (csr_addr_e'(aw_addr) == CSR_STATUS);
    assign wr_ctrl   = wr_accept && (csr_addr_e'(aw_addr) == CSR_CTRL) && w_strb[0];
    assign wr_status = wr_accept && (csr_addr_e'(aw_addr) == CSR_STATUS) && w_strb[0];

    // Self-clearing bits become single-cycle pulses
    assign clear_stats        = wr_ctrl && w_data[CTRL_CLEAR_BIT];
    assign clear_fault_sticky = wr_status && w_data[STAT_STICKY_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            lpmode_q <= 1'b0;
            resetl_q <= 1'b1;
        end else if (wr_ctrl) begin
            lpmode_q <= w_data[CTRL_LPMODE_BIT];
            resetl_q <= w_data[CTRL_RESETL_BIT];
        end
    end

    assign qsfp_lpmode_out = lpmode_q;
    assign qsfp_resetl_out = resetl_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else if (wr_accept) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            b_resp <= wr_ok ? AXI_OKAY : AXI_SLVERR;
        end
    end

    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[CTRL_LPMODE_BIT] = lpmode_q;
        ctrl_word[CTRL_RESETL_BIT] = resetl_q;
    end

    always_comb begin
        status_word                   = '0;
        status_word[STAT_FAULT_BIT]   = fault;
        status_word[STAT_ALIGNED_BIT] = aligned;
        status_word[STAT_STICKY_BIT]  = fault_sticky;
        status_word[STAT_RX_IDLE_BIT] = rx_idle;
        status_word[STAT_TX_IDLE_BIT] = tx_idle;
    end

    // Read side
    assign rd_accept = ar_valid && !r_valid;
    assign ar_ready  = rd_accept;

    always_comb begin
        rd_word = '0;
        rd_resp = AXI_OKAY;
        case (csr_addr_e'(ar_addr))
            CSR_CTRL:       rd_word = ctrl_word;
            CSR_STATUS:     rd_word = status_word;
            CSR_RX_PKT:     rd_word = rx_pkt_cnt;
            CSR_RX_BEAT:    rd_word = rx_beat_cnt;
            CSR_RX_LOST:    rd_word = rx_lost_cnt;
            CSR_RX_BAD_FCS: rd_word = rx_bad_fcs_cnt;
            CSR_RX_MAX:     rd_word = rx_max_pkt;
            CSR_TX_PKT:     rd_word = tx_pkt_cnt;
            CSR_TX_BEAT:    rd_word = tx_beat_cnt;
            CSR_TX_MAX:     rd_word = tx_max_pkt;
            CSR_TX_OVF:     rd_word = tx_ovf_cnt;
            CSR_TX_UNF:     rd_word = tx_unf_cnt;
            default:        rd_resp = AXI_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (rd_accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Value sampled at acceptance and held while r_valid waits
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            r_data <= rd_word;
            r_resp <= rd_resp;
        end
    end

endmodule

/* verilog/stream_stats_pkg.sv */
`include "cmac_settings.svh"

package stream_stats_pkg;

    // One statistics counter
    typedef logic [`STAT_CNT_W-1:0] stat_cnt_t;

    // Bad-FCS count of a single cycle
    typedef logic [`FCS_CNT_W-1:0] fcs_inc_t;

    // Step for the event counters
    localparam stat_cnt_t STAT_ONE = stat_cnt_t'(1);

endpackage

/* verilog/tx_stream_monitor.sv */
module tx_stream_monitor
    import stream_stats_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear_stats,

    input  logic      tx_valid,
    input  logic      tx_ready,
    input  logic      tx_last,
    input  logic      tx_ovf,
    input  logic      tx_unf,

    output stat_cnt_t pkt_cnt,
    output stat_cnt_t beat_cnt,
    output stat_cnt_t max_pkt,
    output stat_cnt_t ovf_cnt,
    output stat_cnt_t unf_cnt,
    output logic      idle
);

    logic      beat_acc;
    logic      pkt_open;
    stat_cnt_t cur_beats;
    stat_cnt_t pkt_len;

    assign beat_acc = tx_valid && tx_ready;
    assign pkt_len  = cur_beats + STAT_ONE;
    assign idle     = !pkt_open;

    // Overflow and underflow count cycles, not packets
    always_ff @(posedge clk) begin
        if (rst || clear_stats) begin
            ovf_cnt  <= '0;
            unf_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            if (tx_ovf) begin
                ovf_cnt <= ovf_cnt + STAT_ONE;
            end
            if (tx_unf) begin
                unf_cnt <= unf_cnt + STAT_ONE;
            end
            if (beat_acc) begin
                beat_cnt <= beat_cnt + STAT_ONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_stats) begin
            pkt_cnt   <= '0;
            max_pkt   <= '0;
            cur_beats <= '0;
            pkt_open  <= 1'b0;
        end else if (beat_acc) begin
            if (tx_last) begin
                pkt_cnt   <= pkt_cnt + STAT_ONE;
                cur_beats <= '0;
                pkt_open  <= 1'b0;
                if (pkt_len > max_pkt) begin
                    max_pkt <= pkt_len;
                end
            end else begin
                cur_beats <= pkt_len;
                pkt_open  <= 1'b1;
            end
        end
    end

endmodule
